// File: bench/host_trace.txt
// columns: kind size ingress_half egress_half expected_count (hex, one test per line)
// kind 01 mem write, 02 mem read, 03 dma write, 04 dma read, 00 idle, ff end
01_08_10_10_08
02_08_00_10_08
01_0c_05_00_0c
02_0c_00_05_0c
01_10_14_00_10
02_10_00_07_10
03_06_08_00_06
04_05_00_08_05
00_06_00_00_00
01_03_02_00_03
02_03_00_02_03
04_09_00_08_09
ff_00_00_00_00

// File: sources.f
verilog/ppfifo_pkg.sv
verilog/host_pkg.sv
verilog/ingress_reader.sv
verilog/word_buffer.sv
verilog/egress_writer.sv
verilog/channel_router.sv
verilog/pcie_host_interface.sv
bench/pcie_host_props.sv
bench/pcie_host_tb.sv

// File: bench/pcie_host_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_host_tb
  import ppfifo_pkg::*;
  import host_pkg::*;
;

  localparam logic [7:0] K_IDLE   = 8'h00;
  localparam logic [7:0] K_MEM_WR = 8'h01;
  localparam logic [7:0] K_MEM_RD = 8'h02;
  localparam logic [7:0] K_DMA_WR = 8'h03;
  localparam logic [7:0] K_DMA_RD = 8'h04;

  logic                   clk;
  logic                   rst;
  logic                   i_pcie_mem_fifo_sel;
  logic                   i_pcie_dma_fifo_sel;
  logic                   i_pcie_data_write_flg;
  logic                   i_pcie_data_read_flg;
  logic [XFER_W-1:0]      i_pcie_data_size;
  logic                   o_pcie_write_fin;
  logic                   o_pcie_read_fin;
  logic                   i_pcie_ingress_fifo_rdy;
  logic                   o_pcie_ingress_fifo_act;
  logic [FIFO_SIZE_W-1:0] i_pcie_ingress_fifo_size;
  logic                   o_pcie_ingress_fifo_stb;
  logic [FIFO_DATA_W-1:0] i_pcie_ingress_fifo_data;
  logic                   i_pcie_ingress_fifo_idle;
  logic [EGR_ACT_W-1:0]   i_pcie_egress_fifo_rdy;
  logic [EGR_ACT_W-1:0]   o_pcie_egress_fifo_act;
  logic [FIFO_SIZE_W-1:0] i_pcie_egress_fifo_size;
  logic                   o_pcie_egress_fifo_stb;
  logic [FIFO_DATA_W-1:0] o_pcie_egress_fifo_data;
  logic                   i_idma_activate;
  logic                   o_idma_ready;
  logic                   i_idma_stb;
  logic [FIFO_SIZE_W-1:0] o_idma_size;
  logic [FIFO_DATA_W-1:0] o_idma_data;
  logic [EGR_ACT_W-1:0]   o_odma_ready;
  logic [EGR_ACT_W-1:0]   i_odma_activate;
  logic                   i_odma_stb;
  logic [FIFO_SIZE_W-1:0] o_odma_size;
  logic [FIFO_DATA_W-1:0] i_odma_data;

  logic [39:0]            trace [32];
  logic [39:0]            entry;
  logic [7:0]             kind;
  int                     size;
  int                     ing_half;
  int                     egr_half;
  int                     expect_cnt;
  logic [FIFO_DATA_W-1:0] ref_q [$];
  logic [FIFO_DATA_W-1:0] exp_word;
  int                     ing_stb_cnt;
  int                     rd_cnt;
  int                     half_cnt;
  int                     hold [EGR_ACT_W];
  logic [EGR_ACT_W-1:0]   prev_act;
  int                     errors;
  int                     checks;
  int                     errs_before;
  int                     prop_fails;
  int                     tests;
  int                     idx;
  int                     cycles;
  int                     limit;
  int unsigned            seed_val;

  pcie_host_interface UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic clear_inputs();
    i_pcie_mem_fifo_sel      <= 1'b0;
    i_pcie_dma_fifo_sel      <= 1'b0;
    i_pcie_data_write_flg    <= 1'b0;
    i_pcie_data_read_flg     <= 1'b0;
    i_pcie_data_size         <= '0;
    i_pcie_ingress_fifo_rdy  <= 1'b0;
    i_pcie_ingress_fifo_size <= '0;
    i_pcie_ingress_fifo_idle <= 1'b0;
    i_pcie_egress_fifo_rdy   <= '0;
    i_pcie_egress_fifo_size  <= '0;
    i_idma_activate          <= 1'b0;
    i_idma_stb               <= 1'b0;
    i_odma_activate          <= '0;
    i_odma_stb               <= 1'b0;
    i_odma_data              <= '0;
  endtask

  task automatic check_all_zero();
    check_val("o_pcie_ingress_fifo_act", o_pcie_ingress_fifo_act, 0);
    check_val("o_pcie_ingress_fifo_stb", o_pcie_ingress_fifo_stb, 0);
    check_val("o_pcie_egress_fifo_act", o_pcie_egress_fifo_act, 0);
    check_val("o_pcie_egress_fifo_stb", o_pcie_egress_fifo_stb, 0);
    check_val("o_pcie_egress_fifo_data", o_pcie_egress_fifo_data, 0);
    check_val("o_pcie_write_fin", o_pcie_write_fin, 0);
    check_val("o_pcie_read_fin", o_pcie_read_fin, 0);
    check_val("o_idma_ready", o_idma_ready, 0);
    check_val("o_idma_size", o_idma_size, 0);
    check_val("o_idma_data", o_idma_data, 0);
    check_val("o_odma_ready", o_odma_ready, 0);
    check_val("o_odma_size", o_odma_size, 0);
  endtask

  task automatic run_mem_write();
    ing_stb_cnt = 0;
    i_pcie_mem_fifo_sel      <= 1'b1;
    i_pcie_data_write_flg    <= 1'b1;
    i_pcie_data_size         <= size;
    i_pcie_ingress_fifo_rdy  <= 1'b1;
    i_pcie_ingress_fifo_size <= ing_half;
    do @(posedge clk); while (!o_pcie_write_fin);
    // extra strobes after finish would show up here
    repeat (4) @(posedge clk);
    check_val("ingress strobe count", ing_stb_cnt, expect_cnt);
    check_val("o_pcie_write_fin", o_pcie_write_fin, 1);
    check_val("buffered word count", ref_q.size(), expect_cnt);
  endtask

  task automatic run_mem_read();
    rd_cnt = 0;
    i_pcie_mem_fifo_sel     <= 1'b1;
    i_pcie_data_read_flg    <= 1'b1;
    i_pcie_data_size        <= size;
    i_pcie_egress_fifo_rdy  <= 2'b11;
    i_pcie_egress_fifo_size <= egr_half;
    do @(posedge clk); while (!o_pcie_read_fin);
    check_val("o_pcie_egress_fifo_act", o_pcie_egress_fifo_act, 0);
    repeat (2) @(posedge clk);
    check_val("egress strobe count", rd_cnt, expect_cnt);
    check_val("reference words left", ref_q.size(), 0);
  endtask

  task automatic run_dma_write();
    int k;
    ing_stb_cnt = 0;
    i_pcie_dma_fifo_sel      <= 1'b1;
    i_pcie_data_write_flg    <= 1'b1;
    i_pcie_data_size         <= size;
    i_pcie_ingress_fifo_rdy  <= 1'b1;
    i_pcie_ingress_fifo_size <= ing_half;
    i_idma_activate          <= 1'b1;
    for (k = 0; k < 2 * size; k++) begin
      @(posedge clk);
      check_val("o_idma_ready", o_idma_ready, i_pcie_ingress_fifo_rdy);
      check_val("o_idma_size", o_idma_size, i_pcie_ingress_fifo_size);
      check_val("o_idma_data", o_idma_data, i_pcie_ingress_fifo_data);
      check_val("o_pcie_ingress_fifo_act", o_pcie_ingress_fifo_act, i_idma_activate);
      check_val("o_pcie_ingress_fifo_stb", o_pcie_ingress_fifo_stb, i_idma_stb);
      check_val("o_pcie_write_fin", o_pcie_write_fin, i_pcie_ingress_fifo_idle);
      i_idma_stb               <= k[0];
      // act drops only on cycles without a strobe
      i_idma_activate          <= k[0] | ~k[1];
      i_pcie_ingress_fifo_idle <= k[1];
      i_pcie_ingress_fifo_rdy  <= ~k[2];
    end
    @(posedge clk);
    i_idma_stb <= 1'b0;
    repeat (2) @(posedge clk);
    check_val("ingress strobe count", ing_stb_cnt, expect_cnt);
  endtask

  task automatic run_dma_read();
    int k;
    int sampled;
    sampled = 0;
    i_pcie_dma_fifo_sel     <= 1'b1;
    i_pcie_data_read_flg    <= 1'b1;
    i_pcie_data_size        <= size;
    i_pcie_egress_fifo_rdy  <= 2'b11;
    i_pcie_egress_fifo_size <= egr_half;
    i_odma_activate         <= 2'b01;
    for (k = 0; k < 2 * size; k++) begin
      @(posedge clk);
      check_val("o_pcie_egress_fifo_stb", o_pcie_egress_fifo_stb, i_odma_stb);
      check_val("o_pcie_egress_fifo_data", o_pcie_egress_fifo_data, i_odma_data);
      check_val("o_pcie_egress_fifo_act", o_pcie_egress_fifo_act, i_odma_activate);
      check_val("o_odma_ready", o_odma_ready, i_pcie_egress_fifo_rdy);
      check_val("o_odma_size", o_odma_size, i_pcie_egress_fifo_size);
      // finish may not show before all strobes are counted
      if (sampled < size) begin
        check_val("o_pcie_read_fin", o_pcie_read_fin, 0);
      end
      if (o_pcie_egress_fifo_stb) begin
        sampled++;
      end
      i_odma_stb      <= k[0];
      i_odma_activate <= {k[1], ~k[1]};
      i_odma_data     <= {16'hd0a0, k[15:0]};
    end
    @(posedge clk);
    if (o_pcie_egress_fifo_stb) begin
      sampled++;
    end
    i_odma_stb <= 1'b0;
    k = 0;
    while (!o_pcie_read_fin && k < 4) begin
      @(posedge clk);
      k++;
    end
    checks++;
    assert (o_pcie_read_fin) else begin
      errors++;
      $display("dma read finish never rose after %0d strobes", sampled);
    end
    check_val("dma strobe count", sampled, expect_cnt);
    i_pcie_data_read_flg <= 1'b0;
    @(posedge clk);
    check_val("o_pcie_read_fin", o_pcie_read_fin, 0);
  endtask

  task automatic run_idle();
    int k;
    i_pcie_data_write_flg    <= 1'b1;
    i_pcie_data_read_flg     <= 1'b1;
    i_pcie_data_size         <= size;
    i_pcie_ingress_fifo_rdy  <= 1'b1;
    i_pcie_ingress_fifo_size <= 24'h10;
    i_pcie_ingress_fifo_idle <= 1'b1;
    i_pcie_egress_fifo_rdy   <= 2'b11;
    i_pcie_egress_fifo_size  <= 24'h10;
    i_idma_activate          <= 1'b1;
    i_idma_stb               <= 1'b1;
    i_odma_activate          <= 2'b01;
    i_odma_stb               <= 1'b1;
    i_odma_data              <= 32'hfeed_0001;
    for (k = 0; k < 2 * size; k++) begin
      @(posedge clk);
      check_all_zero();
      // second half, memory selected but no flag
      if (k == size - 1) begin
        i_pcie_mem_fifo_sel   <= 1'b1;
        i_pcie_data_write_flg <= 1'b0;
        i_pcie_data_read_flg  <= 1'b0;
      end
    end
  endtask

  // ingress fifo, egress halves and reference queue
  always @(posedge clk) begin
    if (o_pcie_ingress_fifo_stb) begin
      ing_stb_cnt++;
      if (kind == K_MEM_WR) begin
        ref_q.push_back(i_pcie_ingress_fifo_data);
      end
      i_pcie_ingress_fifo_data <= $urandom;
    end
    if (kind == K_MEM_RD) begin
      for (int i = 0; i < EGR_ACT_W; i++) begin
        if (o_pcie_egress_fifo_act[i] && !prev_act[i]) begin
          i_pcie_egress_fifo_rdy[i] <= 1'b0;
        end
        if (!o_pcie_egress_fifo_act[i] && prev_act[i]) begin
          hold[i] = 3;
        end else if (hold[i] != 0) begin
          hold[i]--;
          if (hold[i] == 0) begin
            i_pcie_egress_fifo_rdy[i] <= 1'b1;
          end
        end
      end
      if (o_pcie_egress_fifo_act != '0 && prev_act == '0) begin
        half_cnt = 0;
      end
      if (o_pcie_egress_fifo_stb) begin
        half_cnt++;
        rd_cnt++;
        checks++;
        assert (half_cnt <= egr_half) else begin
          errors++;
          $display("egress half received %0d words, more than its size %0d",
                   half_cnt, egr_half);
        end
        checks++;
        assert (ref_q.size() > 0) else begin
          errors++;
          $display("egress strobe arrived with no word left to compare");
        end
        if (ref_q.size() > 0) begin
          exp_word = ref_q.pop_front();
          check_val("o_pcie_egress_fifo_data", o_pcie_egress_fifo_data, exp_word);
        end
      end
    end
    prev_act = o_pcie_egress_fifo_act;
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("timeout after %0d cycles, a test never finished", cycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    seed_val = $urandom(5533);
    errors     = 0;
    checks     = 0;
    prop_fails = 0;
    tests      = 0;
    cycles     = 0;
    limit      = 0;
    kind       = K_IDLE;
    prev_act   = '0;
    hold[0]    = 0;
    hold[1]    = 0;
    half_cnt   = 0;
    rst        = 1'b1;
    i_pcie_mem_fifo_sel      = 1'b0;
    i_pcie_dma_fifo_sel      = 1'b0;
    i_pcie_data_write_flg    = 1'b0;
    i_pcie_data_read_flg     = 1'b0;
    i_pcie_data_size         = '0;
    i_pcie_ingress_fifo_rdy  = 1'b0;
    i_pcie_ingress_fifo_size = '0;
    i_pcie_ingress_fifo_data = $urandom;
    i_pcie_ingress_fifo_idle = 1'b0;
    i_pcie_egress_fifo_rdy   = '0;
    i_pcie_egress_fifo_size  = '0;
    i_idma_activate          = 1'b0;
    i_idma_stb               = 1'b0;
    i_odma_activate          = '0;
    i_odma_stb               = 1'b0;
    i_odma_data              = '0;
    $readmemh("bench/host_trace.txt", trace);
    idx = 0;
    while (idx < 32 && trace[idx][39:32] !== 8'hff && trace[idx][39:32] !== 8'hxx) begin
      limit += trace[idx][31:24] * 8;
      idx++;
    end
    limit += 200;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    idx = 0;
    while (idx < 32 && trace[idx][39:32] !== 8'hff && trace[idx][39:32] !== 8'hxx) begin
      entry       = trace[idx];
      kind        = entry[39:32];
      size        = entry[31:24];
      ing_half    = entry[23:16];
      egr_half    = entry[15:8];
      expect_cnt  = entry[7:0];
      errs_before = errors;
      case (kind)
        K_MEM_WR: run_mem_write();
        K_MEM_RD: run_mem_read();
        K_DMA_WR: run_dma_write();
        K_DMA_RD: run_dma_read();
        default:  run_idle();
      endcase
      @(posedge clk);
      clear_inputs();
      repeat (3) @(posedge clk);
      kind = K_IDLE;
      errors     += UUT.router.props.fail_cnt - prop_fails;
      prop_fails  = UUT.router.props.fail_cnt;
      $display("test %0d kind %0h size %0d: %s", idx, entry[39:32], size,
               (errors == errs_before) ? "ok" : "errors");
      tests++;
      idx++;
    end
    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/pcie_host_props.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_host_props
  import ppfifo_pkg::*;
(
  input wire                    clk,
  input wire                    rst,
  input wire                    i_mem_sel,
  input wire                    i_dma_sel,
  input wire                    o_pcie_ingress_fifo_act,
  input wire                    o_pcie_ingress_fifo_stb,
  input wire [EGR_ACT_W-1:0]    o_pcie_egress_fifo_act,
  input wire                    o_pcie_egress_fifo_stb,
  input wire [FIFO_DATA_W-1:0]  o_pcie_egress_fifo_data,
  input wire                    o_pcie_write_fin,
  input wire                    o_pcie_read_fin,
  input wire                    o_idma_ready,
  input wire [FIFO_SIZE_W-1:0]  o_idma_size,
  input wire [FIFO_DATA_W-1:0]  o_idma_data,
  input wire [EGR_ACT_W-1:0]    o_odma_ready,
  input wire [FIFO_SIZE_W-1:0]  o_odma_size
);

  logic w_routed_zero;

  // failed assertions so far
  int   fail_cnt = 0;

  assign w_routed_zero = ~o_pcie_ingress_fifo_act & ~o_pcie_ingress_fifo_stb &
                         (o_pcie_egress_fifo_act == '0) & ~o_pcie_egress_fifo_stb &
                         (o_pcie_egress_fifo_data == '0) & ~o_pcie_write_fin &
                         ~o_pcie_read_fin & ~o_idma_ready & (o_idma_size == '0) &
                         (o_idma_data == '0) & (o_odma_ready == '0) &
                         (o_odma_size == '0);

  // at most one egress half is held
  egr_act_onehot: assert property (@(posedge clk) disable iff (rst)
    !(&o_pcie_egress_fifo_act))
    else begin
      fail_cnt++;
      $error("both egress act bits high");
    end

  ing_stb_needs_act: assert property (@(posedge clk) disable iff (rst)
    o_pcie_ingress_fifo_stb |-> o_pcie_ingress_fifo_act)
    else begin
      fail_cnt++;
      $error("ingress strobe without act");
    end

  egr_stb_needs_act: assert property (@(posedge clk) disable iff (rst)
    o_pcie_egress_fifo_stb |-> (|o_pcie_egress_fifo_act))
    else begin
      fail_cnt++;
      $error("egress strobe without act");
    end

  // nothing leaks out with no target
  no_target_quiet: assert property (@(posedge clk) disable iff (rst)
    (!i_mem_sel && !i_dma_sel) |-> w_routed_zero)
    else begin
      fail_cnt++;
      $error("routed output nonzero with no target selected");
    end

endmodule

bind channel_router pcie_host_props props (.*);

`default_nettype wire

// File: verilog/pcie_host_interface.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_host_interface
  import ppfifo_pkg::*;
  import host_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_pcie_mem_fifo_sel,
  input  wire                     i_pcie_dma_fifo_sel,
  input  wire                     i_pcie_data_write_flg,
  input  wire                     i_pcie_data_read_flg,
  input  wire [XFER_W-1:0]        i_pcie_data_size,
  output logic                    o_pcie_write_fin,
  output logic                    o_pcie_read_fin,
  input  wire                     i_pcie_ingress_fifo_rdy,
  output logic                    o_pcie_ingress_fifo_act,
  input  wire [FIFO_SIZE_W-1:0]   i_pcie_ingress_fifo_size,
  output logic                    o_pcie_ingress_fifo_stb,
  input  wire [FIFO_DATA_W-1:0]   i_pcie_ingress_fifo_data,
  input  wire                     i_pcie_ingress_fifo_idle,
  input  wire [EGR_ACT_W-1:0]     i_pcie_egress_fifo_rdy,
  output logic [EGR_ACT_W-1:0]    o_pcie_egress_fifo_act,
  input  wire [FIFO_SIZE_W-1:0]   i_pcie_egress_fifo_size,
  output logic                    o_pcie_egress_fifo_stb,
  output logic [FIFO_DATA_W-1:0]  o_pcie_egress_fifo_data,
  input  wire                     i_idma_activate,
  output logic                    o_idma_ready,
  input  wire                     i_idma_stb,
  output logic [FIFO_SIZE_W-1:0]  o_idma_size,
  output logic [FIFO_DATA_W-1:0]  o_idma_data,
  output logic [EGR_ACT_W-1:0]    o_odma_ready,
  input  wire [EGR_ACT_W-1:0]     i_odma_activate,
  input  wire                     i_odma_stb,
  output logic [FIFO_SIZE_W-1:0]  o_odma_size,
  input  wire [FIFO_DATA_W-1:0]   i_odma_data
);

  logic                   w_mem_wr_en;
  logic                   w_mem_rd_en;
  logic                   w_ing_act;
  logic                   w_ing_stb;
  logic                   w_wr_fin;
  logic [EGR_ACT_W-1:0]   w_egr_act;
  logic                   w_egr_stb;
  logic [FIFO_DATA_W-1:0] w_egr_data;
  logic                   w_rd_fin;
  logic                   w_push;
  logic [FIFO_DATA_W-1:0] w_push_data;
  logic                   w_pop;
  logic [FIFO_DATA_W-1:0] w_head;
  logic                   w_full;
  logic                   w_empty;

  channel_router router (
    .clk                      (clk),
    .rst                      (rst),
    .i_mem_sel                (i_pcie_mem_fifo_sel),
    .i_dma_sel                (i_pcie_dma_fifo_sel),
    .i_write_flg              (i_pcie_data_write_flg),
    .i_read_flg               (i_pcie_data_read_flg),
    .i_xfer_size              (i_pcie_data_size),
    .i_pcie_ingress_fifo_rdy  (i_pcie_ingress_fifo_rdy),
    .i_pcie_ingress_fifo_size (i_pcie_ingress_fifo_size),
    .i_pcie_ingress_fifo_data (i_pcie_ingress_fifo_data),
    .i_pcie_ingress_fifo_idle (i_pcie_ingress_fifo_idle),
    .i_pcie_egress_fifo_rdy   (i_pcie_egress_fifo_rdy),
    .i_pcie_egress_fifo_size  (i_pcie_egress_fifo_size),
    .i_mem_ing_act            (w_ing_act),
    .i_mem_ing_stb            (w_ing_stb),
    .i_mem_wr_fin             (w_wr_fin),
    .i_mem_egr_act            (w_egr_act),
    .i_mem_egr_stb            (w_egr_stb),
    .i_mem_egr_data           (w_egr_data),
    .i_mem_rd_fin             (w_rd_fin),
    .i_idma_activate          (i_idma_activate),
    .i_idma_stb               (i_idma_stb),
    .i_odma_activate          (i_odma_activate),
    .i_odma_stb               (i_odma_stb),
    .i_odma_data              (i_odma_data),
    .o_mem_wr_en              (w_mem_wr_en),
    .o_mem_rd_en              (w_mem_rd_en),
    .o_pcie_ingress_fifo_act  (o_pcie_ingress_fifo_act),
    .o_pcie_ingress_fifo_stb  (o_pcie_ingress_fifo_stb),
    .o_pcie_egress_fifo_act   (o_pcie_egress_fifo_act),
    .o_pcie_egress_fifo_stb   (o_pcie_egress_fifo_stb),
    .o_pcie_egress_fifo_data  (o_pcie_egress_fifo_data),
    .o_pcie_write_fin         (o_pcie_write_fin),
    .o_pcie_read_fin          (o_pcie_read_fin),
    .o_idma_ready             (o_idma_ready),
    .o_idma_size              (o_idma_size),
    .o_idma_data              (o_idma_data),
    .o_odma_ready             (o_odma_ready),
    .o_odma_size              (o_odma_size)
  );

  // memory write path, raw ingress fifo into the buffer
  ingress_reader reader (
    .clk         (clk),
    .rst         (rst),
    .i_en        (w_mem_wr_en),
    .i_xfer_size (i_pcie_data_size),
    .i_rdy       (i_pcie_ingress_fifo_rdy),
    .i_size      (i_pcie_ingress_fifo_size),
    .i_data      (i_pcie_ingress_fifo_data),
    .i_buf_full  (w_full),
    .o_act       (w_ing_act),
    .o_stb       (w_ing_stb),
    .o_buf_push  (w_push),
    .o_buf_data  (w_push_data),
    .o_fin       (w_wr_fin)
  );

  word_buffer buffer (
    .clk     (clk),
    .rst     (rst),
    .i_push  (w_push),
    .i_data  (w_push_data),
    .i_pop   (w_pop),
    .o_data  (w_head),
    .o_full  (w_full),
    .o_empty (w_empty)
  );

  // memory read path, buffer head into the egress halves
  egress_writer writer (
    .clk         (clk),
    .rst         (rst),
    .i_en        (w_mem_rd_en),
    .i_xfer_size (i_pcie_data_size),
    .i_rdy       (i_pcie_egress_fifo_rdy),
    .i_size      (i_pcie_egress_fifo_size),
    .i_buf_data  (w_head),
    .i_buf_empty (w_empty),
    .o_act       (w_egr_act),
    .o_stb       (w_egr_stb),
    .o_data      (w_egr_data),
    .o_buf_pop   (w_pop),
    .o_fin       (w_rd_fin)
  );

endmodule

`default_nettype wire

// File: verilog/channel_router.sv
`timescale 1ns/10ps
`default_nettype none

module channel_router
  import ppfifo_pkg::*;
  import host_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_mem_sel,
  input  wire                     i_dma_sel,
  input  wire                     i_write_flg,
  input  wire                     i_read_flg,
  input  wire [XFER_W-1:0]        i_xfer_size,
  input  wire                     i_pcie_ingress_fifo_rdy,
  input  wire [FIFO_SIZE_W-1:0]   i_pcie_ingress_fifo_size,
  input  wire [FIFO_DATA_W-1:0]   i_pcie_ingress_fifo_data,
  input  wire                     i_pcie_ingress_fifo_idle,
  input  wire [EGR_ACT_W-1:0]     i_pcie_egress_fifo_rdy,
  input  wire [FIFO_SIZE_W-1:0]   i_pcie_egress_fifo_size,
  input  wire                     i_mem_ing_act,
  input  wire                     i_mem_ing_stb,
  input  wire                     i_mem_wr_fin,
  input  wire [EGR_ACT_W-1:0]     i_mem_egr_act,
  input  wire                     i_mem_egr_stb,
  input  wire [FIFO_DATA_W-1:0]   i_mem_egr_data,
  input  wire                     i_mem_rd_fin,
  input  wire                     i_idma_activate,
  input  wire                     i_idma_stb,
  input  wire [EGR_ACT_W-1:0]     i_odma_activate,
  input  wire                     i_odma_stb,
  input  wire [FIFO_DATA_W-1:0]   i_odma_data,
  output logic                    o_mem_wr_en,
  output logic                    o_mem_rd_en,
  output logic                    o_pcie_ingress_fifo_act,
  output logic                    o_pcie_ingress_fifo_stb,
  output logic [EGR_ACT_W-1:0]    o_pcie_egress_fifo_act,
  output logic                    o_pcie_egress_fifo_stb,
  output logic [FIFO_DATA_W-1:0]  o_pcie_egress_fifo_data,
  output logic                    o_pcie_write_fin,
  output logic                    o_pcie_read_fin,
  output logic                    o_idma_ready,
  output logic [FIFO_SIZE_W-1:0]  o_idma_size,
  output logic [FIFO_DATA_W-1:0]  o_idma_data,
  output logic [EGR_ACT_W-1:0]    o_odma_ready,
  output logic [FIFO_SIZE_W-1:0]  o_odma_size
);

  logic              w_dma_wr;
  logic              w_dma_rd;
  logic [XFER_W-1:0] r_dma_count;
  logic              r_dma_read_fin;

  // memory wins when both selects are up
  assign o_mem_wr_en = i_mem_sel & i_write_flg;
  assign o_mem_rd_en = i_mem_sel & i_read_flg;
  assign w_dma_wr    = ~i_mem_sel & i_dma_sel & i_write_flg;
  assign w_dma_rd    = ~i_mem_sel & i_dma_sel & i_read_flg;

  // ingress side
  assign o_idma_ready = w_dma_wr ? i_pcie_ingress_fifo_rdy  : 1'b0;
  assign o_idma_size  = w_dma_wr ? i_pcie_ingress_fifo_size : '0;
  assign o_idma_data  = w_dma_wr ? i_pcie_ingress_fifo_data : '0;

  assign o_pcie_ingress_fifo_act = o_mem_wr_en ? i_mem_ing_act   :
                                   w_dma_wr    ? i_idma_activate : 1'b0;
  assign o_pcie_ingress_fifo_stb = o_mem_wr_en ? i_mem_ing_stb   :
                                   w_dma_wr    ? i_idma_stb      : 1'b0;

  // egress side
  assign o_odma_ready = w_dma_rd ? i_pcie_egress_fifo_rdy  : '0;
  assign o_odma_size  = w_dma_rd ? i_pcie_egress_fifo_size : '0;

  assign o_pcie_egress_fifo_act  = o_mem_rd_en ? i_mem_egr_act   :
                                   w_dma_rd    ? i_odma_activate : '0;
  assign o_pcie_egress_fifo_stb  = o_mem_rd_en ? i_mem_egr_stb   :
                                   w_dma_rd    ? i_odma_stb      : 1'b0;
  assign o_pcie_egress_fifo_data = o_mem_rd_en ? i_mem_egr_data  :
                                   w_dma_rd    ? i_odma_data     : '0;

  // dma write is done once the ingress fifo goes idle
  assign o_pcie_write_fin = o_mem_wr_en ? i_mem_wr_fin             :
                            w_dma_wr    ? i_pcie_ingress_fifo_idle : 1'b0;
  assign o_pcie_read_fin  = o_mem_rd_en ? i_mem_rd_fin   :
                            w_dma_rd    ? r_dma_read_fin : 1'b0;

  // count dma egress strobes up to the transfer size
  always_ff @(posedge clk) begin
    if (rst) begin
      r_dma_count    <= '0;
      r_dma_read_fin <= 1'b0;
    end else if (!w_dma_rd) begin
      r_dma_count    <= '0;
      r_dma_read_fin <= 1'b0;
    end else if (r_dma_count < i_xfer_size) begin
      if (i_odma_stb) begin
        r_dma_count <= r_dma_count + 1'b1;
      end
    end else begin
      r_dma_read_fin <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/egress_writer.sv
`timescale 1ns/10ps
`default_nettype none

module egress_writer
  import ppfifo_pkg::*;
  import host_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_en,
  input  wire [XFER_W-1:0]        i_xfer_size,
  input  wire [EGR_ACT_W-1:0]     i_rdy,
  input  wire [FIFO_SIZE_W-1:0]   i_size,
  input  wire [FIFO_DATA_W-1:0]   i_buf_data,
  input  wire                     i_buf_empty,
  output logic [EGR_ACT_W-1:0]    o_act,
  output logic                    o_stb,
  output logic [FIFO_DATA_W-1:0]  o_data,
  output logic                    o_buf_pop,
  output logic                    o_fin
);

  logic [EGR_ACT_W-1:0]   r_act;
  logic [EGR_ACT_W-1:0]   w_pick;
  logic [FIFO_SIZE_W-1:0] r_count;
  logic [FIFO_SIZE_W-1:0] r_size;
  logic [XFER_W-1:0]      r_total;
  logic                   w_half_left;
  logic                   w_xfer_left;
  logic                   w_last;

  // lowest ready half
  assign w_pick = i_rdy & (~i_rdy + 1'b1);

  assign w_half_left = r_count < r_size;
  assign w_xfer_left = r_total < i_xfer_size;

  // buffer head goes out each cycle the buffer has a word
  assign o_stb  = (|r_act) & w_half_left & w_xfer_left & ~i_buf_empty;
  assign w_last = o_stb &
                  ((r_count + 1'b1 == r_size) | (r_total + 1'b1 == i_xfer_size));

  always_ff @(posedge clk) begin
    if (rst) begin
      r_act   <= '0;
      r_count <= '0;
      r_total <= '0;
    end else if (!i_en) begin
      r_act   <= '0;
      r_count <= '0;
      r_total <= '0;
    end else if (r_act == '0) begin
      if ((|i_rdy) && w_xfer_left) begin
        r_act   <= w_pick;
        r_count <= '0;
      end
    end else begin
      if (o_stb) begin
        r_count <= r_count + 1'b1;
        r_total <= r_total + 1'b1;
      end
      if (w_last || !(w_half_left && w_xfer_left)) begin
        r_act <= '0;
      end
    end
  end

  // capacity of the half being taken
  always_ff @(posedge clk) begin
    if (r_act == '0 && (|i_rdy)) begin
      r_size <= i_size;
    end
  end

  assign o_act     = r_act;
  assign o_data    = i_buf_data;
  assign o_buf_pop = o_stb;
  assign o_fin     = (r_total == i_xfer_size) & ~(|r_act);

endmodule

`default_nettype wire

// File: verilog/word_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module word_buffer
  import ppfifo_pkg::*;
  import host_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_push,
  input  wire [FIFO_DATA_W-1:0]   i_data,
  input  wire                     i_pop,
  output logic [FIFO_DATA_W-1:0]  o_data,
  output logic                    o_full,
  output logic                    o_empty
);

  logic [FIFO_DATA_W-1:0] mem [BUF_DEPTH];
  logic [BUF_PTR_W-1:0]   r_wr_ptr;
  logic [BUF_PTR_W-1:0]   r_rd_ptr;
  logic [BUF_CNT_W-1:0]   r_count;

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[r_wr_ptr] <= i_data;
    end
  end

  // pointers wrap naturally at BUF_DEPTH
  always_ff @(posedge clk) begin
    if (rst) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (i_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // head word
  assign o_data  = mem[r_rd_ptr];
  assign o_full  = r_count == BUF_CNT_W'(BUF_DEPTH);
  assign o_empty = r_count == '0;

endmodule

`default_nettype wire

// File: verilog/ingress_reader.sv
`timescale 1ns/10ps
`default_nettype none

module ingress_reader
  import ppfifo_pkg::*;
  import host_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_en,
  input  wire [XFER_W-1:0]        i_xfer_size,
  input  wire                     i_rdy,
  input  wire [FIFO_SIZE_W-1:0]   i_size,
  input  wire [FIFO_DATA_W-1:0]   i_data,
  input  wire                     i_buf_full,
  output logic                    o_act,
  output logic                    o_stb,
  output logic                    o_buf_push,
  output logic [FIFO_DATA_W-1:0]  o_buf_data,
  output logic                    o_fin
);

  logic                   r_act;
  logic [FIFO_SIZE_W-1:0] r_count;
  logic [FIFO_SIZE_W-1:0] r_size;
  logic [XFER_W-1:0]      r_total;
  logic                   w_half_left;
  logic                   w_xfer_left;
  logic                   w_last;

  assign w_half_left = r_count < r_size;
  assign w_xfer_left = r_total < i_xfer_size;

  // one word per cycle, held off by a full buffer
  assign o_stb = r_act & w_half_left & w_xfer_left & ~i_buf_full;

  // final word of the half or of the whole transfer
  assign w_last = o_stb &
                  ((r_count + 1'b1 == r_size) | (r_total + 1'b1 == i_xfer_size));

  always_ff @(posedge clk) begin
    if (rst) begin
      r_act   <= 1'b0;
      r_count <= '0;
      r_total <= '0;
    end else if (!i_en) begin
      r_act   <= 1'b0;
      r_count <= '0;
      r_total <= '0;
    end else if (!r_act) begin
      // re-arm on the next ready half
      if (i_rdy && w_xfer_left) begin
        r_act   <= 1'b1;
        r_count <= '0;
      end
    end else begin
      if (o_stb) begin
        r_count <= r_count + 1'b1;
        r_total <= r_total + 1'b1;
      end
      // release the half after its last strobe, or if it was empty
      if (w_last || !(w_half_left && w_xfer_left)) begin
        r_act <= 1'b0;
      end
    end
  end

  // half size captured when the half is taken
  always_ff @(posedge clk) begin
    if (!r_act && i_rdy) begin
      r_size <= i_size;
    end
  end

  assign o_act      = r_act;
  assign o_buf_push = o_stb;
  assign o_buf_data = i_data;
  assign o_fin      = r_total == i_xfer_size;

endmodule

`default_nettype wire

// File: verilog/host_pkg.sv
`default_nettype none

package host_pkg;

  // host transfer word count
  localparam int XFER_W = 32;

  // on-chip word buffer standing in for ddr3
  localparam int BUF_DEPTH = 16;
  localparam int BUF_PTR_W = 4;

  // one bit wider than the pointer so a full buffer can be counted
  localparam int BUF_CNT_W = 5;

endpackage

`default_nettype wire

// File: verilog/ppfifo_pkg.sv
`default_nettype none

package ppfifo_pkg;

  // one ping-pong fifo word
  localparam int FIFO_DATA_W = 32;

  // size field of a fifo half, in words
  localparam int FIFO_SIZE_W = 24;

  // egress side has two halves, one act bit each
  localparam int EGR_ACT_W = 2;

endpackage

`default_nettype wire
